// ==== files.f ====
+incdir+tests
verilog/exe_pkg.sv
verilog/exe_alu.sv
verilog/exe_branch.sv
verilog/exe_commit.sv
verilog/exe_stage.sv
tests/tb_exe_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  -f files.f --top-module tb_exe_stage -o sim_exe_stage
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_exe_stage > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Result: FAILED" "$LOG"; then
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi
exit 0

// ==== tests/exe_tests.svh ====
/* Directed execute stage tests */

function automatic logic [XLEN-1:0] rand64();
  return {$random(seed), $random(seed)};
endfunction

// OP and OP-IMM result from the ISA definition
function automatic logic [XLEN-1:0] model_op(logic [2:0] f3, logic alt,
                                             logic [XLEN-1:0] a, logic [XLEN-1:0] b);
  logic [XLEN-1:0] res;
  case (f3)
    F3_ADD:  res = alt ? a - b : a + b;
    F3_SLL:  res = a << b[5:0];
    F3_SLT:  res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
    F3_SLTU: res = (a < b) ? 64'd1 : 64'd0;
    F3_XOR:  res = a ^ b;
    F3_SR: begin
      res = a >> b[5:0];
      // sign fill of the vacated upper bits
      if (alt && a[XLEN-1])
        res = res | ~({XLEN{1'b1}} >> b[5:0]);
    end
    F3_OR:   res = a | b;
    default: res = a & b;
  endcase
  return res;
endfunction

task automatic verify_idle();
  check_value("o_valid", o_valid, 1'b0);
  check_value("o_rd_wen", o_rd_wen, 1'b0);
  check_value("o_pc_jmp", o_pc_jmp, 1'b0);
  check_value("o_flush", o_flush, 1'b0);
  check_value("o_memren", o_memren, 1'b0);
  check_value("o_memwen", o_memwen, 1'b0);
endtask

task automatic reset_and_bubbles();
  verify_idle();
  // a jal with both strobes that is never marked valid
  drive(OPC_JAL, 3'd0, 7'd0, rand64(), rand64(), rand64(), '0, 1'b1, 1'b1);
  i_valid = 1'b0;
  drive_bubble();
  verify_idle();
  drive_bubble();
  verify_idle();
endtask

task automatic issue_alu(opcode_e opc, logic [2:0] f3, logic [6:0] f7,
                         logic [XLEN-1:0] a, logic [XLEN-1:0] b, logic [XLEN-1:0] exp);
  drive(opc, f3, f7, a, b, '0, '0, 1'b0, 1'b0);
  drive_bubble();
  wait_valid();
  check_value("o_rd_wen", o_rd_wen, 1'b1);
  check_value("o_rd_data", o_rd_data, exp);
  check_value("o_pc_jmp", o_pc_jmp, 1'b0);
endtask

task automatic alu64_ops();
  logic [XLEN-1:0] a;
  logic [XLEN-1:0] b;
  repeat (4) begin
    for (int f = 0; f < 8; f++) begin
      for (int alt = 0; alt < 2; alt++) begin
        a = rand64();
        b = rand64();
        if (alt == 0 || f[2:0] == F3_ADD || f[2:0] == F3_SR)
          issue_alu(OPC_OP, f[2:0], alt[0] ? 7'h20 : 7'h00, a, b, model_op(f[2:0], alt[0], a, b));
        // no subtract among the immediates
        if (alt == 0 || f[2:0] == F3_SR)
          issue_alu(OPC_OP_IMM, f[2:0], alt[0] ? 7'h20 : 7'h00, a, b,
                    model_op(f[2:0], alt[0], a, b));
      end
    end
  end
  // first result read while the second one is in flight
  a = rand64();
  b = rand64();
  drive(OPC_OP, F3_XOR, 7'h00, a, b, '0, '0, 1'b0, 1'b0);
  drive(OPC_OP, F3_ADD, 7'h20, b, a, '0, '0, 1'b0, 1'b0);
  wait_valid();
  check_value("o_rd_data", o_rd_data, a ^ b);
  drive_bubble();
  wait_valid();
  check_value("o_rd_data", o_rd_data, b - a);
  // o_valid drops one cycle after the last result
  drive_bubble();
  verify_idle();
endtask

// W forms ignore the upper operand bits and copy bit 31 up
task automatic alu32_ops();
  issue_alu(OPC_OP_32, F3_ADD, 7'h00, 64'h1234_5678_7fff_ffff, 64'd1, 64'hffff_ffff_8000_0000);
  issue_alu(OPC_OP_32, F3_ADD, 7'h00, 64'hffff_ffff_0000_0005, 64'h0000_0001_0000_0003,
            64'h0000_0000_0000_0008);
  issue_alu(OPC_OP_IMM_32, F3_ADD, 7'h00, 64'h7fff_ffff, 64'h7fff_ffff, 64'hffff_ffff_ffff_fffe);
  issue_alu(OPC_OP_32, F3_ADD, 7'h20, 64'habcd_0000_0000_0000, 64'd1, 64'hffff_ffff_ffff_ffff);
  issue_alu(OPC_OP_32, F3_SLL, 7'h00, 64'd1, 64'h3f, 64'hffff_ffff_8000_0000);
  issue_alu(OPC_OP_IMM_32, F3_SLL, 7'h00, 64'hc000_0001, 64'h21, 64'hffff_ffff_8000_0002);
  issue_alu(OPC_OP_32, F3_SR, 7'h00, 64'hffff_ffff_8000_0000, 64'd4, 64'h0000_0000_0800_0000);
  issue_alu(OPC_OP_32, F3_SR, 7'h20, 64'h8000_0000, 64'd4, 64'hffff_ffff_f800_0000);
  issue_alu(OPC_OP_IMM_32, F3_SR, 7'h00, 64'h8000_0000, 64'd0, 64'hffff_ffff_8000_0000);
  issue_alu(OPC_OP_IMM_32, F3_SR, 7'h20, 64'h8000_0010, 64'd1, 64'hffff_ffff_c000_0008);
endtask

task automatic cond_branches();
  logic [XLEN-1:0] ops [6];
  logic [2:0]      conds [6];
  logic [XLEN-1:0] x;
  logic [XLEN-1:0] y;
  logic [XLEN-1:0] tgt;
  logic            taken;
  ops   = '{64'd5, 64'd5, 64'hffff_ffff_ffff_fffd, 64'd2, 64'd1, 64'h8000_0000_0000_0000};
  conds = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
  for (int p = 0; p < 3; p++) begin
    for (int s = 0; s < 2; s++) begin
      x = ops[2*p + s];
      y = ops[2*p + 1 - s];
      for (int c = 0; c < 6; c++) begin
        case (conds[c])
          F3_BEQ:  taken = (x == y);
          F3_BNE:  taken = (x != y);
          F3_BLT:  taken = ($signed(x) < $signed(y));
          F3_BGE:  taken = ($signed(x) >= $signed(y));
          F3_BLTU: taken = (x < y);
          default: taken = (x >= y);
        endcase
        tgt = rand64() | 64'd4;
        drive(OPC_BRANCH, conds[c], 7'd0, x, y, tgt, '0, 1'b0, 1'b0);
        drive_bubble();
        wait_valid();
        check_value("o_pc_jmp", o_pc_jmp, taken);
        check_value("o_pc_jmpaddr", o_pc_jmpaddr, tgt);
        check_value("o_rd_wen", o_rd_wen, 1'b0);
        // every taken branch misses the zero prediction
        check_value("o_flush", o_flush, taken);
      end
    end
  end
endtask

task automatic jump_case(opcode_e opc, logic [XLEN-1:0] a, logic [XLEN-1:0] b,
                         logic [XLEN-1:0] t1, logic [XLEN-1:0] pred,
                         logic [XLEN-1:0] link, logic [XLEN-1:0] tgt);
  drive(opc, 3'd0, 7'd0, a, b, t1, pred, 1'b0, 1'b0);
  drive_bubble();
  wait_valid();
  check_value("o_rd_wen", o_rd_wen, 1'b1);
  check_value("o_rd_data", o_rd_data, link);
  check_value("o_pc_jmp", o_pc_jmp, 1'b1);
  check_value("o_pc_jmpaddr", o_pc_jmpaddr, tgt);
  check_value("o_flush", o_flush, tgt != pred);
  if (tgt != pred)
    check_value("o_flush_pc", o_flush_pc, tgt);
endtask

task automatic jumps_and_flush();
  logic [XLEN-1:0] link;
  logic [XLEN-1:0] tgt;
  logic [XLEN-1:0] base;
  logic [XLEN-1:0] offs;
  link = rand64();
  tgt  = rand64();
  // jal takes the link on op1 and the target on op2
  jump_case(OPC_JAL, link, tgt, rand64(), tgt, link, tgt);
  jump_case(OPC_JAL, link, tgt, rand64(), tgt + 64'd4, link, tgt);
  // jalr takes the link on t1 and clears bit 0 of the odd sum
  jump_case(OPC_JALR, 64'h8000_1000, 64'h23, link, 64'h8000_1022, link, 64'h8000_1022);
  jump_case(OPC_JALR, 64'h8000_1000, 64'h23, link, 64'h8000_1023, link, 64'h8000_1022);
  base = rand64() & ~64'd1;
  offs = rand64() | 64'd1;
  jump_case(OPC_JALR, base, offs, link, '0, link, base + offs - 64'd1);
endtask

task automatic misc_case(opcode_e opc, logic ren, logic wen, logic [XLEN-1:0] a,
                         logic [XLEN-1:0] b, logic exp_wen, logic [XLEN-1:0] exp_data);
  drive(opc, 3'd3, 7'd0, a, b, rand64(), rand64(), ren, wen);
  drive_bubble();
  wait_valid();
  check_value("o_memren", o_memren, ren);
  check_value("o_memwen", o_memwen, wen);
  check_value("o_rd_wen", o_rd_wen, exp_wen);
  if (exp_wen)
    check_value("o_rd_data", o_rd_data, exp_data);
  check_value("o_pc_jmp", o_pc_jmp, 1'b0);
  check_value("o_flush", o_flush, 1'b0);
endtask

task automatic mem_and_misc();
  logic [XLEN-1:0] a;
  logic [XLEN-1:0] b;
  a = rand64();
  b = rand64();
  misc_case(OPC_LOAD, 1'b1, 1'b0, a, b, 1'b1, a);
  misc_case(OPC_STORE, 1'b0, 1'b1, a, b, 1'b0, '0);
  misc_case(OPC_LUI, 1'b1, 1'b1, a, b, 1'b1, a);
  misc_case(OPC_AUIPC, 1'b0, 1'b1, a, b, 1'b1, a + b);
  misc_case(OPC_SYSTEM, 1'b1, 1'b1, a, b, 1'b1, a);
endtask

// ==== tests/tb_exe_stage.sv ====
/* Execute stage testbench */

module tb_exe_stage;
  timeunit 1ns;
  timeprecision 100ps;
  import exe_pkg::*;

  localparam int TIMEOUT_CYCLES = 16;

  logic             i_clock;
  logic             i_reset   = 1'b1;
  logic             i_valid   = 1'b0;
  opcode_e          i_opcode  = OPC_OP;
  logic [2:0]       i_funct3  = '0;
  logic [6:0]       i_funct7  = '0;
  logic [XLEN-1:0]  i_op1     = '0;
  logic [XLEN-1:0]  i_op2     = '0;
  logic [XLEN-1:0]  i_t1      = '0;
  logic [XLEN-1:0]  i_pc_pred = '0;
  logic             i_memren  = 1'b0;
  logic             i_memwen  = 1'b0;
  logic             o_valid;
  logic             o_rd_wen;
  logic [XLEN-1:0]  o_rd_data;
  logic             o_pc_jmp;
  logic [XLEN-1:0]  o_pc_jmpaddr;
  logic             o_flush;
  logic [XLEN-1:0]  o_flush_pc;
  logic             o_memren;
  logic             o_memwen;
  integer           seed;

  exe_stage u_exe_stage (.*);

  initial begin
    i_clock = 1'b0;
    forever #20 i_clock = ~i_clock;
  end

  task automatic check_value(string name, logic [XLEN-1:0] actual,
                             logic [XLEN-1:0] expected);
    if (actual !== expected) begin
      $display("Mismatch at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
      $display("Result: FAILED");
      $fatal(1, "value check failed");
    end
  endtask

  // wait for the result of the last sampled instruction
  task automatic wait_valid();
    int cycles;
    cycles = 0;
    while (o_valid !== 1'b1) begin
      if (cycles == TIMEOUT_CYCLES) begin
        $display("Timeout: o_valid did not rise within %0d cycles", TIMEOUT_CYCLES);
        $display("Result: FAILED");
        $fatal(1, "timeout waiting for o_valid");
      end else begin
        @(posedge i_clock);
        #2;
        cycles++;
      end
    end
  endtask

  // new instruction 2 ns after the edge
  task automatic drive(opcode_e opc, logic [2:0] f3, logic [6:0] f7,
                       logic [XLEN-1:0] op1, logic [XLEN-1:0] op2,
                       logic [XLEN-1:0] t1, logic [XLEN-1:0] pred,
                       logic ren, logic wen);
    @(posedge i_clock);
    #2;
    i_valid   = 1'b1;
    i_opcode  = opc;
    i_funct3  = f3;
    i_funct7  = f7;
    i_op1     = op1;
    i_op2     = op2;
    i_t1      = t1;
    i_pc_pred = pred;
    i_memren  = ren;
    i_memwen  = wen;
  endtask

  task automatic drive_bubble();
    @(posedge i_clock);
    #2;
    i_valid = 1'b0;
  endtask

  `include "exe_tests.svh"

  initial begin
    seed = 32'h7365_1078;
    repeat (10) @(posedge i_clock);
    #2;
    i_reset = 1'b0;
    reset_and_bubbles();
    alu64_ops();
    alu32_ops();
    cond_branches();
    jumps_and_flush();
    mem_and_misc();
    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== verilog/exe_stage.sv ====
/* RV64I execute stage */

module exe_stage (
  input  logic                      i_clock,
  input  logic                      i_reset,
  input  logic                      i_valid,
  input  exe_pkg::opcode_e          i_opcode,
  input  logic [2:0]                i_funct3,
  input  logic [6:0]                i_funct7,
  input  logic [exe_pkg::XLEN-1:0]  i_op1,
  input  logic [exe_pkg::XLEN-1:0]  i_op2,
  input  logic [exe_pkg::XLEN-1:0]  i_t1,
  input  logic [exe_pkg::XLEN-1:0]  i_pc_pred,
  input  logic                      i_memren,
  input  logic                      i_memwen,
  output logic                      o_valid,
  output logic                      o_rd_wen,
  output logic [exe_pkg::XLEN-1:0]  o_rd_data,
  output logic                      o_pc_jmp,
  output logic [exe_pkg::XLEN-1:0]  o_pc_jmpaddr,
  output logic                      o_flush,
  output logic [exe_pkg::XLEN-1:0]  o_flush_pc,
  output logic                      o_memren,
  output logic                      o_memwen
);
  import exe_pkg::*;

  logic             alu_rd_wen;
  logic [XLEN-1:0]  alu_rd_data;
  logic             branch_jmp;
  logic [XLEN-1:0]  branch_jmpaddr;

  // write-back path
  exe_alu u_alu (
    .i_opcode  (i_opcode),
    .i_funct3  (i_funct3),
    .i_funct7  (i_funct7),
    .i_op1     (i_op1),
    .i_op2     (i_op2),
    .i_t1      (i_t1),
    .o_rd_wen  (alu_rd_wen),
    .o_rd_data (alu_rd_data)
  );

  // control-flow path, in parallel with the alu
  exe_branch u_branch (
    .i_opcode     (i_opcode),
    .i_funct3     (i_funct3),
    .i_op1        (i_op1),
    .i_op2        (i_op2),
    .i_t1         (i_t1),
    .o_pc_jmp     (branch_jmp),
    .o_pc_jmpaddr (branch_jmpaddr)
  );

  exe_commit u_commit (
    .i_clock      (i_clock),
    .i_reset      (i_reset),
    .i_valid      (i_valid),
    .i_rd_wen     (alu_rd_wen),
    .i_rd_data    (alu_rd_data),
    .i_pc_jmp     (branch_jmp),
    .i_pc_jmpaddr (branch_jmpaddr),
    .i_pc_pred    (i_pc_pred),
    .i_memren     (i_memren),
    .i_memwen     (i_memwen),
    .o_valid      (o_valid),
    .o_rd_wen     (o_rd_wen),
    .o_rd_data    (o_rd_data),
    .o_pc_jmp     (o_pc_jmp),
    .o_pc_jmpaddr (o_pc_jmpaddr),
    .o_flush      (o_flush),
    .o_flush_pc   (o_flush_pc),
    .o_memren     (o_memren),
    .o_memwen     (o_memwen)
  );

endmodule

// ==== verilog/exe_commit.sv ====
/* Execute result register and flush */

module exe_commit (
  input  logic                      i_clock,
  input  logic                      i_reset,
  input  logic                      i_valid,
  input  logic                      i_rd_wen,
  input  logic [exe_pkg::XLEN-1:0]  i_rd_data,
  input  logic                      i_pc_jmp,
  input  logic [exe_pkg::XLEN-1:0]  i_pc_jmpaddr,
  input  logic [exe_pkg::XLEN-1:0]  i_pc_pred,
  input  logic                      i_memren,
  input  logic                      i_memwen,
  output logic                      o_valid,
  output logic                      o_rd_wen,
  output logic [exe_pkg::XLEN-1:0]  o_rd_data,
  output logic                      o_pc_jmp,
  output logic [exe_pkg::XLEN-1:0]  o_pc_jmpaddr,
  output logic                      o_flush,
  output logic [exe_pkg::XLEN-1:0]  o_flush_pc,
  output logic                      o_memren,
  output logic                      o_memwen
);

  logic flush_req;

  // taken jump that went somewhere other than predicted
  assign flush_req = i_pc_jmp && (i_pc_jmpaddr != i_pc_pred);

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      o_valid  <= 1'b0;
      o_rd_wen <= 1'b0;
      o_pc_jmp <= 1'b0;
      o_flush  <= 1'b0;
      o_memren <= 1'b0;
      o_memwen <= 1'b0;
    end else begin
      // bubbles register as all strobes low
      o_valid  <= i_valid;
      o_rd_wen <= i_valid && i_rd_wen;
      o_pc_jmp <= i_valid && i_pc_jmp;
      o_flush  <= i_valid && flush_req;
      o_memren <= i_valid && i_memren;
      o_memwen <= i_valid && i_memwen;
    end
  end

  always_ff @(posedge i_clock) begin
    o_rd_data    <= i_rd_data;
    o_pc_jmpaddr <= i_pc_jmpaddr;
    o_flush_pc   <= i_pc_jmpaddr;
  end

  // a flush is only ever raised by a taken jump
  a_flush_needs_jmp: assert property (
    @(posedge i_clock) disable iff (i_reset) o_flush |-> o_pc_jmp
  );

  a_no_strobe_on_bubble: assert property (
    @(posedge i_clock) disable iff (i_reset)
    !o_valid |-> !(o_rd_wen || o_pc_jmp || o_flush || o_memren || o_memwen)
  );

  a_reset_clears_valid: assert property (
    @(posedge i_clock) i_reset |=> !o_valid
  );

endmodule

// ==== verilog/exe_branch.sv ====
/* Jump decision and target */

module exe_branch (
  input  exe_pkg::opcode_e          i_opcode,
  input  logic [2:0]                i_funct3,
  input  logic [exe_pkg::XLEN-1:0]  i_op1,
  input  logic [exe_pkg::XLEN-1:0]  i_op2,
  input  logic [exe_pkg::XLEN-1:0]  i_t1,
  output logic                      o_pc_jmp,
  output logic [exe_pkg::XLEN-1:0]  o_pc_jmpaddr
);
  import exe_pkg::*;

  logic             is_eq;
  logic             is_lt;
  logic             is_ltu;
  logic             cond_met;
  logic [XLEN-1:0]  jalr_sum;

  assign is_eq    = (i_op1 == i_op2);
  assign is_lt    = ($signed(i_op1) < $signed(i_op2));
  assign is_ltu   = (i_op1 < i_op2);
  assign jalr_sum = i_op1 + i_op2;

  // branch condition from funct3
  always_comb begin
    case (i_funct3)
      F3_BEQ:  cond_met = is_eq;
      F3_BNE:  cond_met = !is_eq;
      F3_BLT:  cond_met = is_lt;
      F3_BGE:  cond_met = !is_lt;
      F3_BLTU: cond_met = is_ltu;
      F3_BGEU: cond_met = !is_ltu;
      default: cond_met = 1'b0;
    endcase
  end

  always_comb begin
    o_pc_jmp     = 1'b0;
    o_pc_jmpaddr = '0;
    case (i_opcode)
      // jal target is precomputed on op2
      OPC_JAL: begin
        o_pc_jmp     = 1'b1;
        o_pc_jmpaddr = i_op2;
      end
      OPC_JALR: begin
        o_pc_jmp     = 1'b1;
        o_pc_jmpaddr = {jalr_sum[XLEN-1:1], 1'b0};
      end
      OPC_BRANCH: begin
        o_pc_jmp     = cond_met;
        o_pc_jmpaddr = i_t1;
      end
      default: begin
        o_pc_jmp     = 1'b0;
        o_pc_jmpaddr = '0;
      end
    endcase
  end

endmodule

// ==== verilog/exe_alu.sv ====
/* Integer ALU and write-back select */

module exe_alu (
  input  exe_pkg::opcode_e          i_opcode,
  input  logic [2:0]                i_funct3,
  input  logic [6:0]                i_funct7,
  input  logic [exe_pkg::XLEN-1:0]  i_op1,
  input  logic [exe_pkg::XLEN-1:0]  i_op2,
  input  logic [exe_pkg::XLEN-1:0]  i_t1,
  output logic                      o_rd_wen,
  output logic [exe_pkg::XLEN-1:0]  o_rd_data
);
  import exe_pkg::*;

  logic             is_sub;
  logic [5:0]       shamt;
  logic [4:0]       shamt_w;
  logic [XLEN-1:0]  full_res;
  logic [31:0]      word_res;

  // funct7[5] is immediate bits for addi/addiw, so sub only on register forms
  assign is_sub  = ((i_opcode == OPC_OP) || (i_opcode == OPC_OP_32)) && i_funct7[5];
  assign shamt   = i_op2[5:0];
  assign shamt_w = i_op2[4:0];

  // 64-bit results for OP and OP-IMM
  always_comb begin
    case (i_funct3)
      F3_ADD: begin
        if (is_sub) begin
          full_res = i_op1 - i_op2;
        end else begin
          full_res = i_op1 + i_op2;
        end
      end
      F3_SLL:  full_res = i_op1 << shamt;
      F3_SLT:  full_res = {{(XLEN-1){1'b0}}, $signed(i_op1) < $signed(i_op2)};
      F3_SLTU: full_res = {{(XLEN-1){1'b0}}, i_op1 < i_op2};
      F3_XOR:  full_res = i_op1 ^ i_op2;
      F3_SR: begin
        // sra / srai
        if (i_funct7[5]) begin
          full_res = $signed(i_op1) >>> shamt;
        end else begin
          full_res = i_op1 >> shamt;
        end
      end
      F3_OR:   full_res = i_op1 | i_op2;
      default: full_res = i_op1 & i_op2;
    endcase
  end

  // 32-bit results for the W forms, sign extended below
  always_comb begin
    case (i_funct3)
      F3_ADD: begin
        if (is_sub) begin
          word_res = i_op1[31:0] - i_op2[31:0];
        end else begin
          word_res = i_op1[31:0] + i_op2[31:0];
        end
      end
      F3_SLL: word_res = i_op1[31:0] << shamt_w;
      F3_SR: begin
        if (i_funct7[5]) begin
          word_res = $signed(i_op1[31:0]) >>> shamt_w;
        end else begin
          word_res = i_op1[31:0] >> shamt_w;
        end
      end
      // no other funct3 in the W groups
      default: word_res = '0;
    endcase
  end

  // write-back enable and data select
  always_comb begin
    o_rd_wen = 1'b1;
    case (i_opcode)
      OPC_LUI, OPC_JAL, OPC_LOAD, OPC_SYSTEM: begin
        o_rd_data = i_op1;
      end
      OPC_AUIPC: begin
        o_rd_data = i_op1 + i_op2;
      end
      // link address comes in on t1
      OPC_JALR: begin
        o_rd_data = i_t1;
      end
      OPC_OP_IMM, OPC_OP: begin
        o_rd_data = full_res;
      end
      OPC_OP_IMM_32, OPC_OP_32: begin
        o_rd_data = {{(XLEN-32){word_res[31]}}, word_res};
      end
      // branch, store and unknown opcodes write nothing
      default: begin
        o_rd_wen  = 1'b0;
        o_rd_data = '0;
      end
    endcase
  end

endmodule

// ==== verilog/exe_pkg.sv ====
/* Execute stage shared definitions */

package exe_pkg;

  // data word width, RV64
  localparam int XLEN = 64;

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    OPC_LUI       = 7'b0110111,
    OPC_AUIPC     = 7'b0010111,
    OPC_JAL       = 7'b1101111,
    OPC_JALR      = 7'b1100111,
    OPC_BRANCH    = 7'b1100011,
    OPC_LOAD      = 7'b0000011,
    OPC_STORE     = 7'b0100011,
    OPC_OP_IMM    = 7'b0010011,
    OPC_OP        = 7'b0110011,
    OPC_OP_IMM_32 = 7'b0011011,
    OPC_OP_32     = 7'b0111011,
    OPC_SYSTEM    = 7'b1110011
  } opcode_e;

  // funct3 for the integer groups
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  // srl and sra, told apart by funct7[5]
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // funct3 for conditional branches
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

endpackage
